/* Bender.yml */
package:
  name: up_core

sources:
  - include_dirs:
      - include
    files:
      - rtl/up_core_pkg.sv
      - rtl/up_memory.sv
      - rtl/up_datapath.sv
      - rtl/up_controller.sv
      - rtl/up_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_up_core.sv

/* all.f */
+incdir+include
rtl/up_core_pkg.sv
rtl/up_memory.sv
rtl/up_datapath.sv
rtl/up_controller.sv
rtl/up_core.sv
sim/tb_up_core.sv

/* include/up_core_defs.svh */
`ifndef UP_CORE_DEFS_SVH
`define UP_CORE_DEFS_SVH

// Data path and memory sizing
`define UP_DATA_W    8
`define UP_ADDR_W    8
`define UP_MEM_SIZE  256

// One instruction per nibble
`define UP_NIB_W     4

// Program starts at the high nibble of byte 4
`define UP_PC_RESET  8'h08

// Stack grows down from the top byte
`define UP_SP_RESET  8'hFF

`endif

/* rtl/up_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module up_controller (
   input  wire                       clk,
   input  wire                       nRst,
   input  wire                       run,
   input  wire up_core_pkg::instr_t  ir,
   input  wire                       eq,
   output up_core_pkg::op_e          op,
   output logic                      ir_we,
   output logic                      pc_we,
   output logic                      sp_we,
   output logic                      rb_we,
   output up_core_pkg::reg_sel_t     rb_sel,
   output logic                      ale,
   output logic                      mem_we
);

   up_core_pkg::state_e state;
   up_core_pkg::state_e state_nxt;
   up_core_pkg::op_e    swap_op;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= up_core_pkg::LOAD_0;
      end else if (!run) begin
         state <= up_core_pkg::LOAD_0;  // Hold at boot start
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      case (state)
         up_core_pkg::LOAD_0: state_nxt = up_core_pkg::LOAD_1;
         up_core_pkg::LOAD_1: state_nxt = up_core_pkg::LOAD_2;
         up_core_pkg::LOAD_2: state_nxt = up_core_pkg::LOAD_3;
         up_core_pkg::LOAD_3: state_nxt = up_core_pkg::LOAD_4;
         up_core_pkg::DECODE: state_nxt = up_core_pkg::EXEC_1;
         up_core_pkg::EXEC_1: begin
            case (ir)
               4'h0, 4'h1, 4'h2, 4'h3, 4'h7, 4'hF: state_nxt = up_core_pkg::FETCH;
               default:                            state_nxt = up_core_pkg::EXEC_2;
            endcase
         end
         up_core_pkg::EXEC_2: begin
            case (ir)
               4'h4, 4'h5, 4'h6, 4'h9, 4'hB: state_nxt = up_core_pkg::EXEC_3;
               default:                      state_nxt = up_core_pkg::FETCH;
            endcase
         end
         up_core_pkg::FETCH:  state_nxt = up_core_pkg::DECODE;
         default:             state_nxt = up_core_pkg::FETCH; // LOAD_4, EXEC_3
      endcase
   end

   // Opcodes 4..6 pick the register pair from ir[1:0]
   always_comb begin
      case (ir[1:0])
         2'd0:    swap_op = up_core_pkg::OP_XOR_01;
         2'd1:    swap_op = up_core_pkg::OP_XOR_12;
         default: swap_op = up_core_pkg::OP_XOR_23;
      endcase
   end

   always_comb begin
      op     = up_core_pkg::OP_C0;
      ir_we  = 1'b0;
      pc_we  = 1'b0;
      sp_we  = 1'b0;
      rb_we  = 1'b0;
      rb_sel = 3'b100;
      ale    = 1'b0;
      mem_we = 1'b0;
      case (state)
         up_core_pkg::LOAD_0: begin
            ale = 1'b1;
         end
         up_core_pkg::LOAD_1: begin
            op     = up_core_pkg::OP_C1;
            rb_sel = 3'b000;
            rb_we  = 1'b1;
            ale    = 1'b1;
         end
         up_core_pkg::LOAD_2: begin
            op     = up_core_pkg::OP_C2;
            rb_sel = 3'b001;
            rb_we  = 1'b1;
            ale    = 1'b1;
         end
         up_core_pkg::LOAD_3: begin
            op     = up_core_pkg::OP_C3;
            rb_sel = 3'b010;
            rb_we  = 1'b1;
            ale    = 1'b1;
         end
         up_core_pkg::LOAD_4: begin
            op     = up_core_pkg::OP_PC_BYTE;
            rb_sel = 3'b011;
            rb_we  = 1'b1;
            ale    = 1'b1;
         end
         up_core_pkg::FETCH: begin
            op  = up_core_pkg::OP_PC_BYTE;
            ale = 1'b1;
         end
         up_core_pkg::DECODE: begin
            op    = up_core_pkg::OP_PC_INC;
            ir_we = 1'b1;
            pc_we = 1'b1;
         end
         up_core_pkg::EXEC_1: begin
            case (ir)
               4'h0: begin
                  op    = up_core_pkg::OP_ADD;
                  rb_we = 1'b1;
               end
               4'h1: begin
                  op    = up_core_pkg::OP_SUB;
                  rb_we = 1'b1;
               end
               4'h2: begin
                  op    = up_core_pkg::OP_MUL;
                  rb_we = 1'b1;
               end
               4'h3: begin
                  op    = up_core_pkg::OP_NAND;
                  rb_we = 1'b1;
               end
               4'h4, 4'h5, 4'h6: begin
                  op     = swap_op;
                  rb_sel = {1'b1, ir[1:0]};
                  rb_we  = 1'b1;
               end
               4'h7: begin
                  op    = up_core_pkg::OP_R3;
                  pc_we = eq;             // Taken only on r1 == r2
               end
               4'h8, 4'hA: begin
                  op    = up_core_pkg::OP_SP_INC;
                  sp_we = 1'b1;
                  ale   = 1'b1;
               end
               4'h9, 4'hB: begin
                  op  = up_core_pkg::OP_SP;
                  ale = 1'b1;
               end
               4'hC, 4'hD: begin
                  op  = up_core_pkg::OP_R3;
                  ale = 1'b1;
               end
               4'hE: begin
                  ale = 1'b1;             // Byte 0
               end
               default: begin
               end
            endcase
         end
         up_core_pkg::EXEC_2: begin
            case (ir)
               4'h4, 4'h5, 4'h6: begin
                  op     = swap_op;
                  rb_sel = {1'b1, ir[1:0] + 2'd1};
                  rb_we  = 1'b1;
               end
               4'h8: begin
                  op    = up_core_pkg::OP_MEM;  // Return address
                  pc_we = 1'b1;
               end
               4'h9, 4'hB: begin
                  op    = up_core_pkg::OP_SP_DEC;
                  sp_we = 1'b1;
               end
               4'hA, 4'hC: begin
                  op     = up_core_pkg::OP_MEM;
                  rb_sel = 3'b010;
                  rb_we  = 1'b1;
               end
               4'hD: begin
                  op     = up_core_pkg::OP_R2;
                  mem_we = 1'b1;
               end
               4'hE: begin
                  op     = up_core_pkg::OP_MEM;
                  rb_sel = 3'b000;
                  rb_we  = 1'b1;
               end
               default: begin
               end
            endcase
         end
         up_core_pkg::EXEC_3: begin
            case (ir)
               4'h4, 4'h5, 4'h6: begin
                  op     = swap_op;
                  rb_sel = {1'b1, ir[1:0]};
                  rb_we  = 1'b1;
               end
               4'h9: begin
                  op     = up_core_pkg::OP_PC_DEC;
                  mem_we = 1'b1;
               end
               4'hB: begin
                  op     = up_core_pkg::OP_R2;
                  mem_we = 1'b1;
               end
               default: begin
               end
            endcase
         end
         default: begin
         end
      endcase
   end

   // Register write and store never share a cycle
   assert property (@(posedge clk) disable iff (!nRst) !(rb_we && mem_we));

   assert property (@(posedge clk) disable iff (!nRst)
      $rose(pc_we) |-> !(state inside {up_core_pkg::LOAD_0, up_core_pkg::LOAD_1,
                                       up_core_pkg::LOAD_2, up_core_pkg::LOAD_3,
                                       up_core_pkg::LOAD_4}));

endmodule

`default_nettype wire

/* rtl/up_core.sv */
`timescale 1ns/1ps
`default_nettype none

module up_core (
   input  wire                      clk,
   input  wire                      nRst,
   input  wire                      run,
   input  wire                      host_we,
   input  wire                      host_rd,
   input  wire up_core_pkg::addr_t  host_addr,
   input  wire up_core_pkg::byte_t  host_wdata,
   output wire up_core_pkg::byte_t  host_rdata
);

   up_core_pkg::op_e      op;
   up_core_pkg::reg_sel_t rb_sel;
   up_core_pkg::instr_t   ir;
   up_core_pkg::byte_t    result;
   up_core_pkg::byte_t    rdata;
   logic                  ir_we;
   logic                  pc_we;
   logic                  sp_we;
   logic                  rb_we;
   logic                  ale;
   logic                  mem_we;
   logic                  eq;

   up_controller ctrl0 (
      .clk    (clk),
      .nRst   (nRst),
      .run    (run),
      .ir     (ir),
      .eq     (eq),
      .op     (op),
      .ir_we  (ir_we),
      .pc_we  (pc_we),
      .sp_we  (sp_we),
      .rb_we  (rb_we),
      .rb_sel (rb_sel),
      .ale    (ale),
      .mem_we (mem_we)
   );

   up_datapath dp0 (
      .clk    (clk),
      .nRst   (nRst),
      .run    (run),
      .op     (op),
      .ir_we  (ir_we),
      .pc_we  (pc_we),
      .sp_we  (sp_we),
      .rb_we  (rb_we),
      .rb_sel (rb_sel),
      .rdata  (rdata),
      .result (result),
      .ir     (ir),
      .eq     (eq)
   );

   // Result bus doubles as address and store data
   up_memory mem0 (
      .clk        (clk),
      .nRst       (nRst),
      .run        (run),
      .ale        (ale),
      .mem_we     (mem_we),
      .wdata      (result),
      .host_we    (host_we),
      .host_rd    (host_rd),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .rdata      (rdata),
      .host_rdata (host_rdata)
   );

endmodule

`default_nettype wire

/* rtl/up_core_pkg.sv */
`default_nettype none

package up_core_pkg;

`include "up_core_defs.svh"

   typedef logic [`UP_DATA_W-1:0] byte_t;
   typedef logic [`UP_ADDR_W-1:0] addr_t;
   typedef logic [`UP_ADDR_W-1:0] pc_t;    // Nibble address
   typedef logic [`UP_NIB_W-1:0]  instr_t;
   typedef logic [2:0]            reg_sel_t; // {use result, reg index}

   typedef enum logic [3:0] {
      LOAD_0,
      LOAD_1,
      LOAD_2,
      LOAD_3,
      LOAD_4,
      FETCH,
      DECODE,
      EXEC_1,
      EXEC_2,
      EXEC_3
   } state_e;

   typedef enum logic [4:0] {
      OP_ADD,
      OP_SUB,
      OP_MUL,
      OP_NAND,
      OP_XOR_01,
      OP_XOR_12,
      OP_XOR_23,
      OP_C0,
      OP_C1,
      OP_C2,
      OP_C3,
      OP_PC_BYTE,   // Byte holding the current nibble
      OP_PC_INC,
      OP_PC_DEC,
      OP_SP,
      OP_SP_INC,
      OP_SP_DEC,
      OP_R2,
      OP_R3,
      OP_MEM
   } op_e;

endpackage

`default_nettype wire

/* rtl/up_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "up_core_defs.svh"

module up_datapath (
   input  wire                         clk,
   input  wire                         nRst,
   input  wire                         run,
   input  wire up_core_pkg::op_e       op,
   input  wire                         ir_we,
   input  wire                         pc_we,
   input  wire                         sp_we,
   input  wire                         rb_we,
   input  wire up_core_pkg::reg_sel_t  rb_sel,
   input  wire up_core_pkg::byte_t     rdata,
   output up_core_pkg::byte_t          result,
   output up_core_pkg::instr_t         ir,
   output logic                        eq
);

   up_core_pkg::byte_t  rf [0:3];
   up_core_pkg::byte_t  sp;
   up_core_pkg::pc_t    pc;
   up_core_pkg::byte_t  wr_data;
   up_core_pkg::instr_t ir_nib;

   always_comb begin
      case (op)
         up_core_pkg::OP_ADD:     result = rf[1] + rf[2];
         up_core_pkg::OP_SUB:     result = rf[1] - rf[2];
         up_core_pkg::OP_MUL:     result = rf[1] * rf[2];  // Low byte only
         up_core_pkg::OP_NAND:    result = ~(rf[1] & rf[2]);
         up_core_pkg::OP_XOR_01:  result = rf[0] ^ rf[1];
         up_core_pkg::OP_XOR_12:  result = rf[1] ^ rf[2];
         up_core_pkg::OP_XOR_23:  result = rf[2] ^ rf[3];
         up_core_pkg::OP_C0:      result = 8'h00;
         up_core_pkg::OP_C1:      result = 8'h01;
         up_core_pkg::OP_C2:      result = 8'h02;
         up_core_pkg::OP_C3:      result = 8'h03;
         up_core_pkg::OP_PC_BYTE: result = pc >> 1;
         up_core_pkg::OP_PC_INC:  result = pc + 8'd1;
         up_core_pkg::OP_PC_DEC:  result = pc - 8'd1;
         up_core_pkg::OP_SP:      result = sp;
         up_core_pkg::OP_SP_INC:  result = sp + 8'd1;
         up_core_pkg::OP_SP_DEC:  result = sp - 8'd1;
         up_core_pkg::OP_R2:      result = rf[2];
         up_core_pkg::OP_R3:      result = rf[3];
         default:                 result = rdata;    // OP_MEM
      endcase
   end

   assign wr_data = rb_sel[2] ? result : rdata;
   assign ir_nib  = pc[0] ? rdata[3:0] : rdata[7:4]; // High nibble first
   assign eq      = (rf[1] == rf[2]);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= `UP_PC_RESET;
         sp <= `UP_SP_RESET;
         ir <= '0;
         for (int i = 0; i < 4; i++) begin
            rf[i] <= '0;
         end
      end else if (!run) begin
         pc <= `UP_PC_RESET;
         sp <= `UP_SP_RESET;
         ir <= '0;
         for (int i = 0; i < 4; i++) begin
            rf[i] <= '0;
         end
      end else begin
         if (pc_we) begin
            pc <= result;
         end
         if (sp_we) begin
            sp <= result;
         end
         if (ir_we) begin
            ir <= ir_nib;
         end
         if (rb_we) begin
            rf[rb_sel[1:0]] <= wr_data;
         end
      end
   end

   // Each IR load comes with a PC step
   assert property (@(posedge clk) disable iff (!nRst) $rose(ir_we) |-> $rose(pc_we));

endmodule

`default_nettype wire

/* rtl/up_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "up_core_defs.svh"

module up_memory (
   input  wire                      clk,
   input  wire                      nRst,
   input  wire                      run,
   input  wire                      ale,
   input  wire                      mem_we,
   input  wire up_core_pkg::byte_t  wdata,
   input  wire                      host_we,
   input  wire                      host_rd,
   input  wire up_core_pkg::addr_t  host_addr,
   input  wire up_core_pkg::byte_t  host_wdata,
   output up_core_pkg::byte_t       rdata,
   output up_core_pkg::byte_t       host_rdata
);

   up_core_pkg::byte_t mem [0:`UP_MEM_SIZE-1];
   up_core_pkg::addr_t addr_latch;

   assign rdata = mem[addr_latch];

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         addr_latch <= '0;
      end else if (run && ale) begin
         addr_latch <= wdata;     // Result bus carries the address
      end
   end

   always_ff @(posedge clk) begin
      if (run) begin
         if (mem_we) begin
            mem[addr_latch] <= wdata;
         end
      end else if (host_we) begin
         mem[host_addr] <= host_wdata;
      end
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         host_rdata <= '0;
      end else if (!run && host_rd) begin
         host_rdata <= mem[host_addr];  // Held until next read
      end
   end

   assert property (@(posedge clk) disable iff (!nRst) run |-> !(host_we || host_rd));

endmodule

`default_nettype wire

/* sim/tb_up_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_up_core;

   localparam int CLK_PERIOD = 4;

   logic       clk;
   logic       nRst;
   logic       run;
   logic       host_we;
   logic       host_rd;
   logic [7:0] host_addr;
   logic [7:0] host_wdata;
   wire  [7:0] host_rdata;

   string      test_name[$];
   int         run_len[$];
   int         prog_first[$];
   int         prog_cnt[$];
   logic [7:0] prog_addr[$];
   logic [7:0] prog_data[$];
   int         exp_first[$];
   int         exp_cnt[$];
   logic [7:0] exp_addr[$];
   logic [7:0] exp_data[$];
   longint     watchdog_ns = 0;
   int         pass_cnt = 0;
   int         fail_cnt = 0;
   bit         file_ok;
   longint     total_cycles;

   up_core dut0 (
      .clk        (clk),
      .nRst       (nRst),
      .run        (run),
      .host_we    (host_we),
      .host_rd    (host_rd),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_rdata (host_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [3:0] hex_nibble(input byte c);
      if (c >= "0" && c <= "9")
         return c - "0";
      if (c >= "a" && c <= "f")
         return c - "a" + 10;
      if (c >= "A" && c <= "F")
         return c - "A" + 10;
      return 4'h0;
   endfunction

   task automatic read_golden(output bit ok);
      int         fd;
      int         n;
      int         cyc;
      int         cur;
      string      line;
      string      tag;
      string      name;
      string      hex;
      logic [7:0] a;
      logic [7:0] d;
      ok = 1'b0;
      fd = $fopen("sim/up_core_golden.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the golden file sim/up_core_golden.txt");
         return;
      end
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n <= 0)
            continue;
         if (line.getc(0) == "#")
            continue;
         n = $sscanf(line, "%s", tag);
         if (n != 1)
            continue;
         cur = test_name.size() - 1;
         if (tag == "T") begin
            n = $sscanf(line, "%s %s %d", tag, name, cyc);
            test_name.push_back(name);
            run_len.push_back(cyc);
            prog_first.push_back(prog_addr.size());
            prog_cnt.push_back(0);
            exp_first.push_back(exp_addr.size());
            exp_cnt.push_back(0);
         end else if (tag == "P" && cur >= 0) begin
            n = $sscanf(line, "%s %h %s", tag, a, hex);
            for (int i = 0; i + 1 < hex.len(); i += 2) begin
               prog_addr.push_back(a);
               prog_data.push_back({hex_nibble(hex.getc(i)), hex_nibble(hex.getc(i + 1))});
               a = a + 8'd1;
               prog_cnt[cur] = prog_cnt[cur] + 1;
            end
         end else if (tag == "E" && cur >= 0) begin
            n = $sscanf(line, "%s %h %h", tag, a, d);
            exp_addr.push_back(a);
            exp_data.push_back(d);
            exp_cnt[cur] = exp_cnt[cur] + 1;
         end
      end
      $fclose(fd);
      ok = (test_name.size() > 0);
   endtask

   task automatic host_write(input logic [7:0] a, input logic [7:0] d);
      @(posedge clk);
      host_we    <= 1'b1;
      host_addr  <= a;
      host_wdata <= d;
   endtask

   task automatic host_release();
      @(posedge clk);
      host_we <= 1'b0;
      host_rd <= 1'b0;
   endtask

   task automatic host_read(input logic [7:0] a, output logic [7:0] d);
      @(posedge clk);
      host_rd   <= 1'b1;
      host_addr <= a;
      @(posedge clk);
      host_rd <= 1'b0;
      @(negedge clk);   // Read data settled
      d = host_rdata;
   endtask

   task automatic run_core(input int cycles);
      @(posedge clk);
      run <= 1'b1;
      repeat (cycles) @(posedge clk);
      run <= 1'b0;
   endtask

   task automatic run_test(input int t);
      int         errs;
      int         k;
      logic [7:0] got;
      errs = 0;
      for (int i = 0; i < 256; i++) begin
         host_write(i[7:0], 8'h00);
      end
      for (int i = 0; i < prog_cnt[t]; i++) begin
         k = prog_first[t] + i;
         host_write(prog_addr[k], prog_data[k]);
      end
      host_release();
      run_core(run_len[t]);
      for (int i = 0; i < exp_cnt[t]; i++) begin
         k = exp_first[t] + i;
         host_read(exp_addr[k], got);
         assert (got === exp_data[k]) else begin
            $display("FAIL %0t: test %s byte %02h expected %02h read %02h",
                     $time, test_name[t], exp_addr[k], exp_data[k], got);
            errs++;
         end
      end
      if (errs == 0) begin
         pass_cnt++;
         $display("PASS test %s", test_name[t]);
      end else begin
         fail_cnt++;
         $display("Test %s ended with %0d mismatches", test_name[t], errs);
      end
   endtask

   initial begin
      nRst       = 1'b0;
      run        = 1'b0;
      host_we    = 1'b0;
      host_rd    = 1'b0;
      host_addr  = 8'h00;
      host_wdata = 8'h00;
      read_golden(file_ok);
      if (!file_ok) begin
         $display("No tests could be read from the golden file");
         $display("Verification failed");
         $finish;
      end else begin
         total_cycles = 20;   // Reset and slack
         for (int t = 0; t < test_name.size(); t++) begin
            total_cycles += run_len[t] + 256 + prog_cnt[t] + 3 * exp_cnt[t] + 4;
         end
         watchdog_ns = 2 * CLK_PERIOD * total_cycles;
         repeat (10) @(posedge clk);
         nRst <= 1'b1;
         for (int t = 0; t < test_name.size(); t++) begin
            run_test(t);
         end
         $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
         if (fail_cnt == 0) begin
            $display("Verification passed");
         end else begin
            $display("Verification failed");
         end
         $finish;
      end
   end

   initial begin
      wait (watchdog_ns > 0);
      #(watchdog_ns);
      $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
      $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

/* sim/up_core_golden.txt */
# T <name> <run cycles> | P <start byte> <hex bytes> | E <byte> <expected byte> | X ends a test
# All values are hex except the run cycles; programs start at nibble 08 and end in a self-loop
T alu_add 60
P 00 00351C0E045D5C7F
E 0E 51
X
T alu_sub 60
P 00 00351C0E145D5C7F
E 0E 19
X
T alu_mul 60
P 00 00351C0E245D5C7F
E 0E CC
X
T alu_nand 60
P 00 00351C0E345D5C7F
E 0E EB
X
T swaps 80
P 00 A1B20EC3645D5C7F
E 0E A1
X
T jump_taken 60
P 00 000D0D0E76D5C7C6D5C70000000013
E 13 0E
E 0D 00
X
T jump_not_taken 60
P 00 00010D0E76D5C7C6D5C70000000013
E 0D 0E
E 13 00
X
T push_pop 50
P 00 00995A0CB5AD7F
E FF 5A
E 0C 5A
X
T call_push 40
P 00 003C3C0A9B7F
E FF 08
E FE 3C
X
T return 40
P 00 000B0B0CB87D7F
E 0C 0B
E FF 0B
X
T loads 90
P 00 6E1020110ECB45D5C70000000000000000A5
E 11 6E
E FF A5
X
